// ==== all.f ====
+incdir+source
source/alu_pipe_pkg.sv
source/fwd_if.sv
source/instr_decoder.sv
source/reg_file.sv
source/operand_forward.sv
source/alu.sv
source/decode_stage.sv
source/exec_pipeline.sv
source/alu_pipe_top.sv
testbench/tb_alu_pipe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_alu_pipe -o tb_alu_pipe
./obj_dir/tb_alu_pipe 2>&1 | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  alu_pipe_pkg::alu_op_e op_i,
  input  alu_pipe_pkg::word_t   a_i,
  input  alu_pipe_pkg::word_t   b_i,
  output alu_pipe_pkg::word_t   result_o
);
  import alu_pipe_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = word_t'(lt_s);
      ALU_SLTU: result_o = word_t'(lt_u);
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== source/alu_pipe_pkg.sv ====
`include "alu_pipe_settings.svh"

package alu_pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`XLEN-1:0]       word_t;

  typedef struct packed {
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    logic      use_imm;
    logic      regwrite;
    logic      illegal;
  } decoded_t;

  // Decode to execute, operands already resolved
  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    reg_addr_t rd;
    logic      regwrite;
    word_t     op_a;
    word_t     op_b;
  } issue_t;

  typedef struct packed {
    logic      valid;
    logic      regwrite;
    reg_addr_t rd;
    word_t     result;
  } stage_t;

endpackage

// ==== source/alu_pipe_settings.svh ====
`ifndef ALU_PIPE_SETTINGS_SVH
`define ALU_PIPE_SETTINGS_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32

// Major opcodes
`define OPCODE_OP     7'b0110011
`define OPCODE_OP_IMM 7'b0010011

// funct3 is shared by the register and immediate forms
`define FUNCT3_ADD_SUB 3'b000
`define FUNCT3_SLL     3'b001
`define FUNCT3_SLT     3'b010
`define FUNCT3_SLTU    3'b011
`define FUNCT3_XOR     3'b100
`define FUNCT3_SRL_SRA 3'b101
`define FUNCT3_OR      3'b110
`define FUNCT3_AND     3'b111

`endif

// ==== source/alu_pipe_top.sv ====
`timescale 1ns/1ps

module alu_pipe_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  input  alu_pipe_pkg::word_t     instr_i,
  output logic                   wb_valid_o,
  output alu_pipe_pkg::reg_addr_t wb_rd_o,
  output alu_pipe_pkg::word_t     wb_data_o
);
  import alu_pipe_pkg::*;

  issue_t issue;

  fwd_if u_fwd ();

  // Writeback outputs also close the loop to the register file
  decode_stage u_decode_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .fwd           (u_fwd.sink),
    .wb_we_i       (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o),
    .issue_o       (issue)
  );

  exec_pipeline u_exec_pipeline (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .issue_i    (issue),
    .fwd        (u_fwd.source),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  input  alu_pipe_pkg::word_t     instr_i,
  fwd_if.sink                    fwd,
  input  logic                   wb_we_i,
  input  alu_pipe_pkg::reg_addr_t wb_rd_i,
  input  alu_pipe_pkg::word_t     wb_data_i,
  output alu_pipe_pkg::issue_t    issue_o
);
  import alu_pipe_pkg::*;

  logic     if_id_valid_q;
  word_t    if_id_instr_q;
  decoded_t dec;
  word_t    rf_rs1;
  word_t    rf_rs2;
  word_t    fwd_a;
  word_t    fwd_b;

  // IF/ID register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      if_id_valid_q <= 1'b0;
    end else begin
      if_id_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if_id_instr_q <= instr_i;
  end

  instr_decoder u_decoder (
    .instr_i (if_id_instr_q),
    .dec_o   (dec)
  );

  reg_file u_reg_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_i      (dec.rs1),
    .rs2_i      (dec.rs2),
    .rs1_data_o (rf_rs1),
    .rs2_data_o (rf_rs2),
    .we_i       (wb_we_i),
    .wd_addr_i  (wb_rd_i),
    .wd_data_i  (wb_data_i)
  );

  operand_forward u_operand_forward (
    .rs1_i    (dec.rs1),
    .rs2_i    (dec.rs2),
    .rf_rs1_i (rf_rs1),
    .rf_rs2_i (rf_rs2),
    .fwd      (fwd),
    .op_a_o   (fwd_a),
    .op_b_o   (fwd_b)
  );

  // Illegal encodings leave as bubbles
  always_comb begin
    issue_o.valid    = if_id_valid_q && !dec.illegal;
    issue_o.alu_op   = dec.alu_op;
    issue_o.rd       = dec.rd;
    issue_o.regwrite = dec.regwrite;
    issue_o.op_a     = fwd_a;
    issue_o.op_b     = dec.use_imm ? dec.imm : fwd_b;
  end

endmodule

// ==== source/exec_pipeline.sv ====
`timescale 1ns/1ps

module exec_pipeline (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  alu_pipe_pkg::issue_t    issue_i,
  fwd_if.source                  fwd,
  output logic                   wb_valid_o,
  output alu_pipe_pkg::reg_addr_t wb_rd_o,
  output alu_pipe_pkg::word_t     wb_data_o
);
  import alu_pipe_pkg::*;

  issue_t id_ex_q;
  word_t  alu_result;
  stage_t ex_stage;
  stage_t ex_mem_q;
  stage_t mem_wb_q;

  // ID/EX
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_ex_q.valid <= 1'b0;
    end else begin
      id_ex_q <= issue_i;
    end
  end

  alu u_alu (
    .op_i     (id_ex_q.alu_op),
    .a_i      (id_ex_q.op_a),
    .b_i      (id_ex_q.op_b),
    .result_o (alu_result)
  );

  always_comb begin
    ex_stage.valid    = id_ex_q.valid;
    ex_stage.regwrite = id_ex_q.regwrite;
    ex_stage.rd       = id_ex_q.rd;
    ex_stage.result   = alu_result;
  end

  // EX/MEM, the memory slot only carries the result
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_mem_q.valid <= 1'b0;
    end else begin
      ex_mem_q <= ex_stage;
    end
  end

  // MEM/WB
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mem_wb_q.valid <= 1'b0;
    end else begin
      mem_wb_q <= ex_mem_q;
    end
  end

  assign fwd.ex  = ex_stage;
  assign fwd.mem = ex_mem_q;
  assign fwd.wb  = mem_wb_q;

  assign wb_valid_o = mem_wb_q.valid && mem_wb_q.regwrite;
  assign wb_rd_o    = mem_wb_q.rd;
  assign wb_data_o  = mem_wb_q.result;

endmodule

// ==== source/fwd_if.sv ====
`timescale 1ns/1ps

interface fwd_if;
  import alu_pipe_pkg::*;

  // Producer stages, youngest first
  stage_t ex;
  stage_t mem;
  stage_t wb;

  modport source (
    output ex,
    output mem,
    output wb
  );

  modport sink (
    input ex,
    input mem,
    input wb
  );

endinterface

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`include "alu_pipe_settings.svh"

module instr_decoder (
  input  alu_pipe_pkg::word_t    instr_i,
  output alu_pipe_pkg::decoded_t dec_o
);
  import alu_pipe_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_op;
  logic       is_op_imm;
  logic       std_f7;
  logic       alt_f7;
  logic       f_ok;
  logic       legal;
  alu_op_e    op_sel;
  reg_addr_t  rd;
  word_t      imm;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign rd        = instr_i[11:7];
  assign is_op     = (opcode == `OPCODE_OP);
  assign is_op_imm = (opcode == `OPCODE_OP_IMM);
  assign std_f7    = (funct7 == 7'b0000000);
  assign alt_f7    = (funct7 == 7'b0100000);

  // Bit 30 selects SUB and SRA; the immediate forms have no SUBI
  always_comb begin
    op_sel = ALU_ADD;
    f_ok   = 1'b0;
    case (funct3)
      `FUNCT3_ADD_SUB: begin
        op_sel = (is_op && instr_i[30]) ? ALU_SUB : ALU_ADD;
        f_ok   = is_op_imm || std_f7 || alt_f7;
      end
      `FUNCT3_SLL: begin
        op_sel = ALU_SLL;
        f_ok   = std_f7;
      end
      `FUNCT3_SLT: begin
        op_sel = ALU_SLT;
        f_ok   = is_op_imm || std_f7;
      end
      `FUNCT3_SLTU: begin
        op_sel = ALU_SLTU;
        f_ok   = is_op_imm || std_f7;
      end
      `FUNCT3_XOR: begin
        op_sel = ALU_XOR;
        f_ok   = is_op_imm || std_f7;
      end
      `FUNCT3_SRL_SRA: begin
        op_sel = instr_i[30] ? ALU_SRA : ALU_SRL;
        f_ok   = std_f7 || alt_f7;
      end
      `FUNCT3_OR: begin
        op_sel = ALU_OR;
        f_ok   = is_op_imm || std_f7;
      end
      `FUNCT3_AND: begin
        op_sel = ALU_AND;
        f_ok   = is_op_imm || std_f7;
      end
    endcase
  end

  assign legal = (is_op || is_op_imm) && f_ok;

  // Shift-immediates carry shamt, not a signed value
  always_comb begin
    if (funct3 == `FUNCT3_SLL || funct3 == `FUNCT3_SRL_SRA) begin
      imm = word_t'(instr_i[24:20]);
    end else begin
      imm = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    end
  end

  always_comb begin
    dec_o.alu_op   = op_sel;
    dec_o.rs1      = instr_i[19:15];
    dec_o.rs2      = instr_i[24:20];
    dec_o.rd       = rd;
    dec_o.imm      = imm;
    dec_o.use_imm  = is_op_imm;
    dec_o.illegal  = !legal;
    dec_o.regwrite = legal && (rd != '0);
  end

endmodule

// ==== source/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
  input  alu_pipe_pkg::reg_addr_t rs1_i,
  input  alu_pipe_pkg::reg_addr_t rs2_i,
  input  alu_pipe_pkg::word_t     rf_rs1_i,
  input  alu_pipe_pkg::word_t     rf_rs2_i,
  fwd_if.sink                    fwd,
  output alu_pipe_pkg::word_t     op_a_o,
  output alu_pipe_pkg::word_t     op_b_o
);
  import alu_pipe_pkg::*;

  // regwrite is already clear for rd == x0, so x0 never matches
  function automatic logic hit(stage_t s, reg_addr_t rs);
    return s.valid && s.regwrite && (s.rd == rs);
  endfunction

  function automatic word_t pick(
    reg_addr_t rs,
    word_t     rf_val,
    stage_t    ex,
    stage_t    mem,
    stage_t    wb
  );
    if (hit(ex, rs)) begin
      return ex.result;
    end else if (hit(mem, rs)) begin
      return mem.result;
    end else if (hit(wb, rs)) begin
      // Register file write of this value lands on the next edge
      return wb.result;
    end
    return rf_val;
  endfunction

  assign op_a_o = pick(rs1_i, rf_rs1_i, fwd.ex, fwd.mem, fwd.wb);
  assign op_b_o = pick(rs2_i, rf_rs2_i, fwd.ex, fwd.mem, fwd.wb);

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "alu_pipe_settings.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  alu_pipe_pkg::reg_addr_t rs1_i,
  input  alu_pipe_pkg::reg_addr_t rs2_i,
  output alu_pipe_pkg::word_t     rs1_data_o,
  output alu_pipe_pkg::word_t     rs2_data_o,
  input  logic                   we_i,
  input  alu_pipe_pkg::reg_addr_t wd_addr_i,
  input  alu_pipe_pkg::word_t     wd_data_i
);
  import alu_pipe_pkg::*;

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wd_addr_i != '0) begin
      regs[wd_addr_i] <= wd_data_i;
    end
  end

  // x0 reads as zero regardless of contents
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== testbench/tb_alu_pipe.sv ====
`timescale 1ns/1ps
`include "alu_pipe_settings.svh"

module tb_alu_pipe;
  import alu_pipe_pkg::*;

  localparam logic [6:0] F7_STD = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;
  localparam logic [6:0] F7_MUL = 7'b0000001;

  typedef struct packed {
    logic      valid;
    word_t     instr;
    logic      wb;
    reg_addr_t rd;
    word_t     data;
  } row_t;

  typedef struct packed {
    logic [15:0] row;
    reg_addr_t   rd;
    word_t       data;
  } wb_exp_t;

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      instr_valid_i;
  word_t     instr_i;
  logic      wb_valid_o;
  reg_addr_t wb_rd_o;
  word_t     wb_data_o;

  row_t    rows[$];
  wb_exp_t exp_q[$];
  wb_exp_t pending;
  wb_exp_t head;
  int      cycle_count;
  int      cycle_limit;
  int      drain;

  alu_pipe_top u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  always #50 clk = ~clk;

  function automatic word_t enc_reg(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, `OPCODE_OP};
  endfunction

  function automatic word_t enc_imm(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, `OPCODE_OP_IMM};
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                          $time, what, actual, expected));
    end
  endtask

  task automatic push_row(input logic valid, input word_t instr, input logic wb,
                          input reg_addr_t rd, input word_t data);
    row_t r;
    r.valid = valid;
    r.instr = instr;
    r.wb    = wb;
    r.rd    = rd;
    r.data  = data;
    rows.push_back(r);
  endtask

  task automatic expect_wb(input word_t instr, input reg_addr_t rd, input word_t data);
    push_row(1'b1, instr, 1'b1, rd, data);
  endtask

  task automatic expect_none(input word_t instr);
    push_row(1'b1, instr, 1'b0, 5'd0, 32'h0);
  endtask

  task automatic idle_slot(input word_t instr);
    push_row(1'b0, instr, 1'b0, 5'd0, 32'h0);
  endtask

  // Expected values worked out by hand from the RV32I rules
  task automatic build_table();
    // Constants from x0
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd1, 5'd0, 12'd5), 5'd1, 32'h0000_0005);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd2, 5'd0, 12'hFFD), 5'd2, 32'hFFFF_FFFD);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd3, 5'd0, 12'h7FF), 5'd3, 32'h0000_07FF);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd4, 5'd0, 12'h800), 5'd4, 32'hFFFF_F800);
    // Distance 1, 2 and 3 on rs1 and rs2 and a register file read
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd5, 5'd4, 12'd1), 5'd5, 32'hFFFF_F801);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd6, 5'd5, 5'd1), 5'd6, 32'hFFFF_F806);
    expect_wb(enc_reg(F7_ALT, `FUNCT3_ADD_SUB, 5'd7, 5'd2, 5'd6), 5'd7, 32'h0000_07F7);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd8, 5'd5, 5'd0), 5'd8, 32'hFFFF_F801);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd9, 5'd7, 5'd0), 5'd9, 32'h0000_07F7);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd10, 5'd0, 5'd7), 5'd10, 32'h0000_07F7);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd11, 5'd0, 5'd9), 5'd11, 32'h0000_07F7);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd12, 5'd11, 5'd10), 5'd12, 32'h0000_0FEE);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd13, 5'd12, 5'd9), 5'd13, 32'h0000_17E5);
    // The youngest of three x14 writers in flight wins
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd14, 5'd0, 12'd100), 5'd14, 32'h0000_0064);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd14, 5'd0, 12'd200), 5'd14, 32'h0000_00C8);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd14, 5'd0, 12'd300), 5'd14, 32'h0000_012C);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd15, 5'd14, 5'd14), 5'd15, 32'h0000_0258);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd16, 5'd14, 12'd1), 5'd16, 32'h0000_012D);
    // Load x20 = -16, x21 = 4, x22 = 1 and x23 = 0x80000000
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd20, 5'd0, 12'hFF0), 5'd20, 32'hFFFF_FFF0);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd21, 5'd0, 12'd4), 5'd21, 32'h0000_0004);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd22, 5'd0, 12'd1), 5'd22, 32'h0000_0001);
    expect_wb(enc_imm(`FUNCT3_SLL, 5'd23, 5'd22, 12'h01F), 5'd23, 32'h8000_0000);
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd24, 5'd20, 5'd21), 5'd24, 32'hFFFF_FFF4);
    expect_wb(enc_reg(F7_ALT, `FUNCT3_ADD_SUB, 5'd25, 5'd21, 5'd20), 5'd25, 32'h0000_0014);
    expect_wb(enc_reg(F7_STD, `FUNCT3_SLL, 5'd26, 5'd20, 5'd21), 5'd26, 32'hFFFF_FF00);
    expect_wb(enc_reg(F7_STD, `FUNCT3_SLT, 5'd27, 5'd20, 5'd21), 5'd27, 32'h0000_0001);
    expect_wb(enc_reg(F7_STD, `FUNCT3_SLTU, 5'd28, 5'd20, 5'd21), 5'd28, 32'h0000_0000);
    expect_wb(enc_reg(F7_STD, `FUNCT3_XOR, 5'd29, 5'd20, 5'd21), 5'd29, 32'hFFFF_FFF4);
    expect_wb(enc_reg(F7_STD, `FUNCT3_SRL_SRA, 5'd30, 5'd20, 5'd21), 5'd30, 32'h0FFF_FFFF);
    expect_wb(enc_reg(F7_ALT, `FUNCT3_SRL_SRA, 5'd31, 5'd20, 5'd21), 5'd31, 32'hFFFF_FFFF);
    expect_wb(enc_reg(F7_STD, `FUNCT3_OR, 5'd17, 5'd23, 5'd22), 5'd17, 32'h8000_0001);
    expect_wb(enc_reg(F7_STD, `FUNCT3_AND, 5'd18, 5'd20, 5'd25), 5'd18, 32'h0000_0010);
    // Shift amount is the low 5 bits of x20 which are 16
    expect_wb(enc_reg(F7_STD, `FUNCT3_SLL, 5'd19, 5'd22, 5'd20), 5'd19, 32'h0001_0000);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd1, 5'd20, 12'hFFF), 5'd1, 32'hFFFF_FFEF);
    expect_wb(enc_imm(`FUNCT3_SLT, 5'd2, 5'd20, 12'hFF1), 5'd2, 32'h0000_0001);
    expect_wb(enc_imm(`FUNCT3_SLTU, 5'd3, 5'd21, 12'hFFF), 5'd3, 32'h0000_0001);
    expect_wb(enc_imm(`FUNCT3_XOR, 5'd4, 5'd20, 12'hFFF), 5'd4, 32'h0000_000F);
    expect_wb(enc_imm(`FUNCT3_OR, 5'd5, 5'd21, 12'h0F0), 5'd5, 32'h0000_00F4);
    expect_wb(enc_imm(`FUNCT3_AND, 5'd6, 5'd20, 12'h7FF), 5'd6, 32'h0000_07F0);
    expect_wb(enc_imm(`FUNCT3_SRL_SRA, 5'd8, 5'd23, 12'h01F), 5'd8, 32'h0000_0001);
    expect_wb(enc_imm(`FUNCT3_SRL_SRA, 5'd9, 5'd23, 12'h41F), 5'd9, 32'hFFFF_FFFF);
    expect_wb(enc_imm(`FUNCT3_SRL_SRA, 5'd10, 5'd20, 12'h402), 5'd10, 32'hFFFF_FFFC);
    expect_wb(enc_reg(F7_STD, `FUNCT3_SLT, 5'd11, 5'd23, 5'd22), 5'd11, 32'h0000_0001);
    expect_wb(enc_reg(F7_STD, `FUNCT3_SLTU, 5'd12, 5'd23, 5'd22), 5'd12, 32'h0000_0000);
    // x0 as destination and read back as zero
    expect_none(enc_imm(`FUNCT3_ADD_SUB, 5'd0, 5'd21, 12'd7));
    expect_none(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd0, 5'd20, 5'd20));
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd14, 5'd0, 5'd21), 5'd14, 32'h0000_0004);
    // Illegal encodings and idle slots between real writers
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd16, 5'd0, 12'h123), 5'd16, 32'h0000_0123);
    expect_none(32'h0000_2803);
    idle_slot(enc_imm(`FUNCT3_ADD_SUB, 5'd16, 5'd0, 12'h555));
    expect_none(enc_reg(F7_MUL, `FUNCT3_ADD_SUB, 5'd16, 5'd21, 5'd21));
    expect_none(enc_reg(F7_ALT, `FUNCT3_SLL, 5'd16, 5'd21, 5'd21));
    expect_wb(enc_reg(F7_STD, `FUNCT3_ADD_SUB, 5'd17, 5'd16, 5'd16), 5'd17, 32'h0000_0246);
    idle_slot(32'h0);
    expect_wb(enc_imm(`FUNCT3_ADD_SUB, 5'd18, 5'd17, 12'd1), 5'd18, 32'h0000_0247);
    idle_slot(32'h0);
    idle_slot(32'h0);
    expect_wb(enc_reg(F7_STD, `FUNCT3_XOR, 5'd19, 5'd18, 5'd17), 5'd19, 32'h0000_0001);
  endtask

  // Writeback monitor samples on the falling edge away from the driving edge
  always @(negedge clk) begin
    if (!rst_n_i) begin
      if (wb_valid_o !== 1'b0) begin
        abort_run("wb_valid_o was not low during reset");
      end
    end else if (wb_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("Unexpected writeback to x%0d at %0d ns", wb_rd_o, $time));
      end else begin
        head = exp_q.pop_front();
        check_value(word_t'(wb_rd_o), word_t'(head.rd), $sformatf("rd of row %0d", head.row));
        check_value(wb_data_o, head.data, $sformatf("data of row %0d", head.row));
      end
    end else if (wb_valid_o !== 1'b0) begin
      abort_run("wb_valid_o is unknown after reset");
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    cycle_count   = 0;
    build_table();
    // Table, reset, pipeline latency and margin
    cycle_limit = rows.size() + 2 + 3 + 20;
    repeat (2) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    foreach (rows[i]) begin
      instr_valid_i = rows[i].valid;
      instr_i       = rows[i].instr;
      if (rows[i].wb) begin
        pending.row  = 16'(i);
        pending.rd   = rows[i].rd;
        pending.data = rows[i].data;
        exp_q.push_back(pending);
      end
      @(posedge clk);
      #1;
    end
    instr_valid_i = 1'b0;
    instr_i       = '0;
    drain = 0;
    while (exp_q.size() != 0 && drain < 8) begin
      @(posedge clk);
      drain++;
    end
    // Idle cycles to catch a stray writeback
    repeat (3) @(posedge clk);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected writebacks never appeared", exp_q.size()));
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule
